// File: rtl/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

	// --------------------------------------------------
	// sprite descriptor

	// colour mode, off means the entry is skipped
	typedef enum logic [1:0] {
		MODE_OFF = 2'd0,	// inactive
		MODE_4C  = 2'd1,	// 8 px x 2 bit
		MODE_16C = 2'd2,	// 4 px x 4 bit
		MODE_TC  = 2'd3	// 2 px true colour
	} color_mode_e;

	typedef struct packed {
		color_mode_e mode;
		logic [5:0]  pal;	// palette bank
		logic [8:0]  ypos;	// first line
		logic [7:0]  height;	// lines, 0 = none
		logic [8:0]  xpos;	// first pixel
		logic [7:0]  xwords;	// width in words, 0 = none
		logic [20:0] base;	// word address of row 0
		logic        pad;	// fills up to 64 bits
	} sprite_desc_t;

	// --------------------------------------------------
	// pixel data

	typedef struct packed {
		logic       spare;
		logic       opaque;
		logic [5:0] color;
	} tc_pixel_t;

	// one fetched word, index 0 is always the leftmost pixel
	typedef union packed {
		logic [0:7][1:0] c4;
		logic [0:3][3:0] c16;
		tc_pixel_t [0:1] tc;
	} pixel_word_u;

	// palette entry
	typedef struct packed {
		logic       transparent;
		logic [5:0] color;
	} pal_entry_t;

	// line buffer entry, valid = something was drawn here
	typedef struct packed {
		logic       valid;
		logic [5:0] color;
	} lb_pixel_t;

	typedef struct packed {
		logic       we;
		logic [8:0] x;
		lb_pixel_t  pix;
	} lb_write_t;

	// --------------------------------------------------
	// wishbone classic, read only master

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic [20:0] adr;	// word address
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [15:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: rtl/sprite_attr_ram.sv
`timescale 1ns/1ps
`default_nettype none

// descriptor table, one entry per sprite
module sprite_attr_ram import sprite_pkg::*; #(
	parameter int NUM_SPRITES = 16
) (
	input  logic                           clk,

	// host side
	input  logic                           desc_we,
	input  logic [$clog2(NUM_SPRITES)-1:0] desc_addr,
	input  sprite_desc_t                   desc_data,

	// sequencer side
	input  logic [$clog2(NUM_SPRITES)-1:0] attr_rd_idx,
	output sprite_desc_t                   attr_desc
);

	sprite_desc_t mem [NUM_SPRITES];	// contents survive line_start

	// --------------------------------------------------
	// write port

	always_ff @(posedge clk)
	begin
		if (desc_we)
		begin
			mem[desc_addr] <= desc_data;	// single strobe from host
		end
	end

	// --------------------------------------------------
	// read port, one cycle latency

	// same-entry collision gives the old value
	always_ff @(posedge clk)
	begin
		attr_desc <= mem[attr_rd_idx];
	end

endmodule

`default_nettype wire

// File: rtl/sprite_seq.sv
`timescale 1ns/1ps
`default_nettype none

// walks the descriptor table once per line and fetches visible rows
module sprite_seq import sprite_pkg::*; #(
	parameter int NUM_SPRITES = 16
) (
	input  logic                           clk,
	input  logic                           line_start,	// async reset, per line
	input  logic [8:0]                     vline,

	// descriptor table
	output logic [$clog2(NUM_SPRITES)-1:0] attr_rd_idx,
	input  sprite_desc_t                   attr_desc,

	// pixel memory
	output wb_req_t                        wb_o,
	input  wb_rsp_t                        wb_i,

	// word handover to the unpacker
	output logic                           word_valid,
	output pixel_word_u                    word,
	output color_mode_e                    mode,
	output logic [5:0]                     pal,
	output logic [8:0]                     x_start,
	input  logic                           word_ready,

	output logic                           busy
);

	localparam int IW = $clog2(NUM_SPRITES);

	localparam logic [2:0] S_INIT = 3'd0;	// after line_start
	localparam logic [2:0] S_RD   = 3'd1;	// wait for descriptor read
	localparam logic [2:0] S_DESC = 3'd2;	// visibility test
	localparam logic [2:0] S_REQ  = 3'd3;	// bus cycle open
	localparam logic [2:0] S_HAND = 3'd4;	// word waits for unpacker
	localparam logic [2:0] S_DONE = 3'd5;	// table finished

	logic [2:0]    state;
	logic [IW-1:0] idx;	// current sprite
	logic [20:0]   adr;	// next word address
	logic [7:0]    words_left;
	logic [8:0]    dy;	// line within sprite
	logic [16:0]   row_offs;
	logic          visible;
	logic          last_sprite;
	logic          last_word;
	logic [3:0]    ppw;	// pixels per word

	// --------------------------------------------------
	// descriptor decode

	assign dy = vline - attr_desc.ypos;
	assign row_offs = dy * attr_desc.xwords;	// row start offset in words

	// plain 9 bit compare, a sprite near the bottom does not wrap to the top
	assign visible = (attr_desc.mode != MODE_OFF)
		&& (attr_desc.height != 8'd0)
		&& (attr_desc.xwords != 8'd0)
		&& (vline >= attr_desc.ypos)
		&& (dy < {1'b0, attr_desc.height});

	assign last_sprite = &idx;	// NUM_SPRITES is a power of two
	assign last_word = (words_left == 8'd1);

	always_comb
	begin
		case (mode)
			MODE_4C:  ppw = 4'd8;
			MODE_16C: ppw = 4'd4;
			default:  ppw = 4'd2;	// true colour
		endcase
	end

	// --------------------------------------------------
	// control FSM

	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			state <= S_INIT;
			idx <= '0;
		end
		else
		begin
			case (state)
				S_INIT:
					state <= S_DESC;	// entry 0 gets read on this edge
				S_RD:
					state <= S_DESC;
				S_DESC:
				begin
					if (visible)
						state <= S_REQ;
					else if (last_sprite)
						state <= S_DONE;
					else
					begin
						idx <= idx + 1'b1;	// skip this one
						state <= S_RD;
					end
				end
				S_REQ:
				begin
					if (wb_i.ack)
						state <= S_HAND;	// cyc drops for at least one cycle
				end
				S_HAND:
				begin
					if (word_ready)
					begin
						if (!last_word)
							state <= S_REQ;	// fetch overlaps unpacking
						else if (last_sprite)
							state <= S_DONE;
						else
						begin
							idx <= idx + 1'b1;
							state <= S_RD;
						end
					end
				end
				default:
					state <= S_DONE;	// idle till next line_start
			endcase
		end
	end

	// --------------------------------------------------
	// fetch datapath

	always_ff @(posedge clk)
	begin
		if (state == S_DESC)
		begin
			adr <= attr_desc.base + {4'd0, row_offs};
			words_left <= attr_desc.xwords;
			x_start <= attr_desc.xpos;
			mode <= attr_desc.mode;
			pal <= attr_desc.pal;
		end
		if ((state == S_REQ) && wb_i.ack)
		begin
			word <= wb_i.dat;
			adr <= adr + 21'd1;	// adr only moves while stb is low
		end
		if ((state == S_HAND) && word_ready)
		begin
			words_left <= words_left - 8'd1;
			x_start <= x_start + {5'd0, ppw};	// wraps at 512
		end
	end

	assign wb_o.cyc = (state == S_REQ);
	assign wb_o.stb = (state == S_REQ);
	assign wb_o.adr = adr;

	assign word_valid = (state == S_HAND);
	assign attr_rd_idx = idx;
	assign busy = (state != S_INIT) && (state != S_DONE);

endmodule

`default_nettype wire

// File: rtl/pixel_unpack.sv
`timescale 1ns/1ps
`default_nettype none

// splits fetched words into pixels and resolves colour and transparency
module pixel_unpack import sprite_pkg::*; (
	input  logic        clk,
	input  logic        line_start,

	// word from the sequencer
	input  logic        word_valid,
	input  pixel_word_u word,
	input  color_mode_e mode,
	input  logic [5:0]  pal,
	input  logic [8:0]  x_start,
	output logic        word_ready,

	// palette writes from host
	input  logic        pal_we,
	input  logic [7:0]  pal_addr,
	input  logic [6:0]  pal_data,

	output lb_write_t   lb_wr
);

	pal_entry_t  pal_mem [256];

	// holding register
	logic        hold_vld;
	logic        armed;	// low during line_start
	logic [2:0]  cnt;	// pixel within word
	logic [2:0]  cnt_last;
	pixel_word_u hold_word;
	color_mode_e hold_mode;
	logic [5:0]  hold_pal;
	logic [8:0]  hold_x;
	logic        take;
	logic        last_pix;
	logic [7:0]  pal_rd_addr;

	// palette stage
	logic        s2_vld;
	logic        s2_tc;
	tc_pixel_t   s2_tcpix;
	logic [8:0]  s2_x;
	pal_entry_t  pal_q;

	// --------------------------------------------------
	// pixel shifter

	always_comb
	begin
		case (hold_mode)
			MODE_4C:  cnt_last = 3'd7;
			MODE_16C: cnt_last = 3'd3;
			MODE_TC:  cnt_last = 3'd1;
			default:  cnt_last = 3'd0;
		endcase
	end

	assign last_pix = (cnt == cnt_last);
	assign word_ready = armed && (!hold_vld || last_pix);	// next word on last pixel
	assign take = word_valid && word_ready;

	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			armed <= 1'b0;
			hold_vld <= 1'b0;
			cnt <= 3'd0;
			s2_vld <= 1'b0;
		end
		else
		begin
			armed <= 1'b1;
			s2_vld <= hold_vld;
			if (take)
			begin
				hold_vld <= 1'b1;
				cnt <= 3'd0;
			end
			else if (hold_vld)
			begin
				if (last_pix)
					hold_vld <= 1'b0;
				else
					cnt <= cnt + 3'd1;
			end
		end
	end

	// palette address is bank followed by pixel index
	always_comb
	begin
		case (hold_mode)
			MODE_4C:  pal_rd_addr = {hold_pal, hold_word.c4[cnt]};
			MODE_16C: pal_rd_addr = {hold_pal[5:2], hold_word.c16[cnt[1:0]]};
			default:  pal_rd_addr = 8'd0;	// tc bypasses palette
		endcase
	end

	// --------------------------------------------------
	// word load, palette lookup

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			hold_word <= word;
			hold_mode <= mode;
			hold_pal <= pal;
			hold_x <= x_start;
		end
		if (pal_we)
			pal_mem[pal_addr] <= pal_data;
		pal_q <= pal_mem[pal_rd_addr];
		s2_tc <= (hold_mode == MODE_TC);
		s2_tcpix <= hold_word.tc[cnt[0]];
		s2_x <= hold_x + {6'd0, cnt};	// mod 512
	end

	// --------------------------------------------------
	// line buffer write

	assign lb_wr.we = s2_vld && (s2_tc ? s2_tcpix.opaque : !pal_q.transparent);
	assign lb_wr.x = s2_x;
	assign lb_wr.pix.valid = 1'b1;
	assign lb_wr.pix.color = s2_tc ? s2_tcpix.color : pal_q.color;

endmodule

`default_nettype wire

// File: rtl/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// double line buffer: one bank is drawn, the other one scanned and cleared
module line_buffer import sprite_pkg::*; #(
	parameter int LINE_W = 360
) (
	input  logic                      clk,
	input  logic                      line_start,
	input  logic [8:0]                vline,	// bit 0 selects render bank
	input  lb_write_t                 lb_wr,
	output logic                      pix_valid,
	output logic [$clog2(LINE_W)-1:0] pix_x,
	output lb_pixel_t                 pix
);

	localparam int XW = $clog2(LINE_W);

	logic          wr_ok;	// write inside the line
	logic          scan_bank;
	logic [XW-1:0] scan_x;	// read address
	logic          scan_done;
	logic [XW-1:0] rd_x;	// address of the word in bank_q
	logic          rd_vld;
	lb_pixel_t     bank_q [2];

	assign wr_ok = lb_wr.we && (lb_wr.x < 9'(LINE_W));	// clip right edge
	assign scan_bank = ~vline[0];

	// --------------------------------------------------
	// banks

	for (genvar b = 0; b < 2; b++)
	begin : g_bank
		lb_pixel_t mem [LINE_W];
		logic      render_here;

		assign render_here = (vline[0] == 1'(b));

		always_ff @(posedge clk)
		begin
			if (render_here && wr_ok)
				mem[lb_wr.x] <= lb_wr.pix;	// later sprite overwrites
			else if (!render_here && rd_vld)
				mem[rd_x] <= '0;	// clear one cycle behind the read
			bank_q[b] <= mem[scan_x];
		end
	end

	// --------------------------------------------------
	// scan counter

	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			scan_x <= '0;
			scan_done <= 1'b0;
			rd_vld <= 1'b0;
			pix_valid <= 1'b0;
		end
		else
		begin
			rd_vld <= !scan_done;
			pix_valid <= rd_vld;
			if (!scan_done)
			begin
				if (scan_x == XW'(LINE_W - 1))
					scan_done <= 1'b1;	// stop till next line
				else
					scan_x <= scan_x + 1'b1;
			end
		end
	end

	// output register
	always_ff @(posedge clk)
	begin
		rd_x <= scan_x;
		pix_x <= rd_x;
		pix <= bank_q[scan_bank];
	end

endmodule

`default_nettype wire

// File: rtl/sprite_engine.sv
`timescale 1ns/1ps
`default_nettype none

// per-line sprite engine top
module sprite_engine import sprite_pkg::*; #(
	parameter int NUM_SPRITES = 16,
	parameter int LINE_W      = 360
) (
	input  logic                           clk,
	input  logic                           line_start,	// async, restarts each line
	input  logic [8:0]                     vline,

	// host writes
	input  logic                           desc_we,
	input  logic [$clog2(NUM_SPRITES)-1:0] desc_addr,
	input  sprite_desc_t                   desc_data,
	input  logic                           pal_we,
	input  logic [7:0]                     pal_addr,
	input  logic [6:0]                     pal_data,

	// pixel memory
	output wb_req_t                        wb_o,
	input  wb_rsp_t                        wb_i,

	// scanout
	output logic                           pix_valid,
	output logic [$clog2(LINE_W)-1:0]      pix_x,
	output lb_pixel_t                      pix,

	output logic                           busy
);

	// --------------------------------------------------
	// internal wires

	logic [$clog2(NUM_SPRITES)-1:0] attr_rd_idx;
	sprite_desc_t                   attr_desc;
	logic                           word_valid;
	logic                           word_ready;
	pixel_word_u                    word;
	color_mode_e                    mode;
	logic [5:0]                     pal;
	logic [8:0]                     x_start;
	lb_write_t                      lb_wr;

	sprite_seq #(
		.NUM_SPRITES (NUM_SPRITES)
	) u_seq (
		.clk         (clk),
		.line_start  (line_start),
		.vline       (vline),
		.attr_rd_idx (attr_rd_idx),
		.attr_desc   (attr_desc),
		.wb_o        (wb_o),
		.wb_i        (wb_i),
		.word_valid  (word_valid),
		.word        (word),
		.mode        (mode),
		.pal         (pal),
		.x_start     (x_start),
		.word_ready  (word_ready),
		.busy        (busy)
	);

	sprite_attr_ram #(
		.NUM_SPRITES (NUM_SPRITES)
	) u_attr (
		.clk         (clk),
		.desc_we     (desc_we),
		.desc_addr   (desc_addr),
		.desc_data   (desc_data),
		.attr_rd_idx (attr_rd_idx),
		.attr_desc   (attr_desc)
	);

	pixel_unpack u_unpack (
		.clk         (clk),
		.line_start  (line_start),
		.word_valid  (word_valid),
		.word        (word),
		.mode        (mode),
		.pal         (pal),
		.x_start     (x_start),
		.word_ready  (word_ready),
		.pal_we      (pal_we),
		.pal_addr    (pal_addr),
		.pal_data    (pal_data),
		.lb_wr       (lb_wr)
	);

	line_buffer #(
		.LINE_W      (LINE_W)
	) u_lbuf (
		.clk         (clk),
		.line_start  (line_start),
		.vline       (vline),
		.lb_wr       (lb_wr),
		.pix_valid   (pix_valid),
		.pix_x       (pix_x),
		.pix         (pix)
	);

endmodule

`default_nettype wire

// File: testbench/sprite_engine_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// bus and scanout properties, bound into the sequencer and the line buffer
module sprite_engine_asserts import sprite_pkg::*; #(
	parameter int LINE_W = 360
) (
	input logic                      clk,
	input logic                      line_start,
	input wb_req_t                   wb_o,
	input wb_rsp_t                   wb_i,
	input logic                      pix_valid,
	input logic [$clog2(LINE_W)-1:0] pix_x
);

	localparam int XW = $clog2(LINE_W);

	// --------------------------------------------------
	// wishbone classic

	a_stb_cyc: assert property (@(posedge clk) disable iff (line_start)
		wb_o.stb |-> wb_o.cyc)
		else $error("stb high without cyc");

	// request held with a steady address until the slave acks
	a_stb_hold: assert property (@(posedge clk) disable iff (line_start)
		(wb_o.stb && !wb_i.ack) |=> (wb_o.stb && $stable(wb_o.adr)))
		else $error("request dropped or address moved before ack");

	a_cyc_gap: assert property (@(posedge clk) disable iff (line_start)
		(wb_o.stb && wb_i.ack) |=> !wb_o.cyc)	// one idle cycle between requests
		else $error("cyc still high the cycle after ack");

	// --------------------------------------------------
	// scanout

	a_scan_range: assert property (@(posedge clk) disable iff (line_start)
		pix_valid |-> ({1'b0, pix_x} < (XW + 1)'(LINE_W)))
		else $error("pix_valid with pix_x outside the line");

endmodule

bind sprite_seq sprite_engine_asserts u_bus_asserts (
	.clk        (clk),
	.line_start (line_start),
	.wb_o       (wb_o),
	.wb_i       (wb_i),
	.pix_valid  (1'b0),	// no scanout here
	.pix_x      ('0)
);

bind line_buffer sprite_engine_asserts #(
	.LINE_W     (LINE_W)
) u_scan_asserts (
	.clk        (clk),
	.line_start (line_start),
	.wb_o       ('0),	// quiet bus
	.wb_i       ('0),
	.pix_valid  (pix_valid),
	.pix_x      (pix_x)
);

`default_nettype wire

// File: testbench/sprite_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

// line by line check of the sprite engine against a model of the rendering rules
module sprite_engine_tb
	import sprite_pkg::*;
();

	localparam int NUM_SPRITES = 16;
	localparam int LINE_W      = 360;
	localparam int IW          = $clog2(NUM_SPRITES);
	localparam int XW          = $clog2(LINE_W);
	localparam int LINE_LIMIT  = 5000;	// cycles per line
	localparam int QUIET       = 12;	// unpacker drains within 10 cycles

	// --------------------------------------------------
	// DUT signals

	logic          clk;
	logic          line_start;
	logic [8:0]    vline;
	logic          desc_we;
	logic [IW-1:0] desc_addr;
	sprite_desc_t  desc_data;
	logic          pal_we;
	logic [7:0]    pal_addr;
	logic [6:0]    pal_data;
	wb_req_t       wb_o;
	wb_rsp_t       wb_i = '0;
	logic          pix_valid;
	logic [XW-1:0] pix_x;
	lb_pixel_t     pix;
	logic          busy;

	// --------------------------------------------------
	// model state

	sprite_desc_t desc_m [NUM_SPRITES];	// copy of the descriptor table
	logic [6:0]   pal_m [256];
	logic [6:0]   exp_line [2][LINE_W];	// indexed by vline bit 0
	int           wait_left = -1;	// -1 = no request seen yet
	int           fetch_total = 0;
	int           max_wait;
	int           line_no;
	bit           hung = 1'b0;	// a line ran out of cycles
	string        test_name;
	int           test_cnt;
	int           test_errs;
	int           test_chk0;
	int           checks;
	int           errors;

	sprite_engine #(
		.NUM_SPRITES (NUM_SPRITES),
		.LINE_W      (LINE_W)
	) dut0 (
		.clk        (clk),
		.line_start (line_start),
		.vline      (vline),
		.desc_we    (desc_we),
		.desc_addr  (desc_addr),
		.desc_data  (desc_data),
		.pal_we     (pal_we),
		.pal_addr   (pal_addr),
		.pal_data   (pal_data),
		.wb_o       (wb_o),
		.wb_i       (wb_i),
		.pix_valid  (pix_valid),
		.pix_x      (pix_x),
		.pix        (pix),
		.busy       (busy)
	);

	always #5 clk = ~clk;

	// pixel memory contents, a hash of the word address
	function automatic logic [15:0] mem_word(input logic [20:0] a);
		logic [31:0] h;
		h = {11'd0, a} * 32'h9E37_79B1;
		h = h ^ (h >> 15);
		return h[15:0] ^ h[31:16];
	endfunction

	// --------------------------------------------------
	// wishbone slave, 0..max_wait wait states per request

	always @(posedge clk)
	begin
		#1;
		if (wb_i.ack)
			wb_i.ack = 1'b0;	// single cycle ack
		else if (wb_o.cyc === 1'b1 && wb_o.stb === 1'b1)
		begin
			if (wait_left < 0)
				wait_left = $urandom_range(max_wait);
			if (wait_left == 0)
			begin
				wb_i.ack = 1'b1;
				wb_i.dat = mem_word(wb_o.adr);
				fetch_total = fetch_total + 1;
				wait_left = -1;
			end
			else
				wait_left = wait_left - 1;
		end
		else
			wait_left = -1;
	end

	// --------------------------------------------------
	// reference model of one line

	task automatic build_model(input int ln, output int nwords);
		sprite_desc_t d;
		int           dy;
		int           ppw;
		int           x;
		logic [15:0]  w;
		logic [7:0]   t8;
		logic [6:0]   e;
		logic         opaque;
		nwords = 0;
		for (int i = 0; i < LINE_W; i++)
			exp_line[ln % 2][i] = 7'd0;	// bank was cleared by its last scan
		for (int s = 0; s < NUM_SPRITES; s++)	// ascending, later wins
		begin
			d = desc_m[s];
			dy = ln - int'(d.ypos);
			if (d.mode == MODE_OFF || d.height == 8'd0 || d.xwords == 8'd0)
				continue;
			if (dy < 0 || dy >= int'(d.height))
				continue;
			ppw = (d.mode == MODE_4C) ? 8 : ((d.mode == MODE_16C) ? 4 : 2);
			for (int k = 0; k < int'(d.xwords); k++)
			begin
				w = mem_word(21'(int'(d.base) + dy * int'(d.xwords) + k));
				nwords++;
				for (int p = 0; p < ppw; p++)
				begin
					x = (int'(d.xpos) + k * ppw + p) % 512;
					if (d.mode == MODE_4C)
						e = pal_m[{d.pal, w[15 - 2 * p -: 2]}];
					else if (d.mode == MODE_16C)
						e = pal_m[{d.pal[5:2], w[15 - 4 * p -: 4]}];
					else
					begin
						t8 = w[15 - 8 * p -: 8];	// spare, opaque, colour
						e = {~t8[6], t8[5:0]};
					end
					opaque = !e[6];
					if (opaque && x < LINE_W)
						exp_line[ln % 2][x] = {1'b1, e[5:0]};
				end
			end
		end
	endtask

	// --------------------------------------------------
	// error and test bookkeeping

	task automatic value_error(input string what, input int x, input logic [31:0] expv,
		input logic [31:0] act);
		errors++;
		test_errs++;
		if (test_errs <= 10)
			$display("[ERROR] test=%s line=%0d %s x=%0d expected=%h actual=%h",
				test_name, line_no, what, x, expv, act);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
		test_chk0 = checks;
	endtask

	task automatic end_test();
		test_cnt++;
		$display("test %s: %s, %0d checks, %0d errors", test_name,
			(test_errs == 0) ? "pass" : "fail", checks - test_chk0, test_errs);
	endtask

	// --------------------------------------------------
	// host writes

	task automatic write_desc(input int s, input sprite_desc_t d);
		@(posedge clk);
		#1;
		desc_we = 1'b1;
		desc_addr = IW'(s);
		desc_data = d;
		@(posedge clk);
		#1;
		desc_we = 1'b0;
		desc_m[s] = d;
	endtask

	task automatic set_pal(input logic [7:0] a, input logic [6:0] v);
		@(posedge clk);
		#1;
		pal_we = 1'b1;
		pal_addr = a;
		pal_data = v;
		@(posedge clk);
		#1;
		pal_we = 1'b0;
		pal_m[a] = v;
	endtask

	function automatic sprite_desc_t make_desc(input color_mode_e m, input logic [5:0] p,
		input int y, input int h, input int x, input int nw, input logic [20:0] b);
		sprite_desc_t d;
		d.mode = m;
		d.pal = p;
		d.ypos = 9'(y);
		d.height = 8'(h);
		d.xpos = 9'(x);
		d.xwords = 8'(nw);
		d.base = b;
		d.pad = 1'b0;
		return d;
	endfunction

	// sprite somewhere around line y0, any mode including off
	function automatic sprite_desc_t rand_desc(input int y0);
		return make_desc(color_mode_e'(2'($urandom_range(3))), 6'($urandom),
			y0 - 6 + int'($urandom_range(12)), 1 + int'($urandom_range(11)),
			int'($urandom_range(511)), 1 + int'($urandom_range(5)), 21'($urandom));
	endfunction

	task automatic clear_table();
		for (int s = 0; s < NUM_SPRITES; s++)
			write_desc(s, make_desc(MODE_OFF, 6'd0, 0, 0, 0, 0, 21'd0));
	endtask

	// --------------------------------------------------
	// one line: render line_no, scan out and check line_no-1

	task automatic run_line();
		int   edges;
		int   seen;
		int   quiet;
		int   nwords;
		int   base_cnt;
		int   prev;
		bit   done;
		bit   check;
		logic exp_v;
		if (hung)
			return;	// engine stuck, nothing left to compare
		prev = (line_no + 1) % 2;
		check = (line_no >= 2);	// both banks scanned once by then
		build_model(line_no, nwords);
		@(posedge clk);
		#1;
		if (busy !== 1'b0)
		begin
			errors++;
			test_errs++;
			$display("busy still high at line_start of line %0d in test %s", line_no, test_name);
		end
		vline = 9'(line_no);
		line_start = 1'b1;
		@(posedge clk);
		#1;
		line_start = 1'b0;
		base_cnt = fetch_total;
		edges = 0;
		seen = 0;
		quiet = 0;
		done = 1'b0;
		while (!done && edges < LINE_LIMIT)
		begin
			@(negedge clk);
			if (edges == 1 && busy !== 1'b1)	// table walk starts on the first edge
				value_error("busy", 0, 32'd1, 32'(busy));
			exp_v = (edges >= 2) && (edges <= LINE_W + 1);	// pixel x on edge x+2
			if (pix_valid !== exp_v)
				value_error("pix_valid", edges - 2, 32'(exp_v), 32'(pix_valid));
			else if (exp_v)
			begin
				seen++;
				if (pix_x !== XW'(edges - 2))
					value_error("pix_x", edges - 2, 32'(edges - 2), 32'(pix_x));
				if (check)
				begin
					checks++;
					if (pix !== exp_line[prev][edges - 2])
						value_error("pixel", edges - 2, 32'(exp_line[prev][edges - 2]), 32'(pix));
				end
			end
			if (edges >= 2 && busy === 1'b0)
				quiet++;
			else
				quiet = 0;
			done = (seen == LINE_W) && (edges > LINE_W + 1) && (quiet >= QUIET);
			edges++;
		end
		if (!done)
		begin
			errors++;
			test_errs++;
			hung = 1'b1;
			$display("timeout: line %0d in test %s did not finish in %0d cycles, busy=%b",
				line_no, test_name, LINE_LIMIT, busy);
		end
		else
		begin
			checks++;
			if (fetch_total - base_cnt != nwords)
				value_error("fetch count", 0, 32'(nwords), 32'(fetch_total - base_cnt));
			line_no++;
		end
	endtask

	// --------------------------------------------------
	// test sequence

	initial
	begin
		logic [5:0] p16;
		void'($urandom(32'h8394));
		clk = 1'b0;
		line_start = 1'b1;
		vline = 9'd0;
		desc_we = 1'b0;
		desc_addr = '0;
		desc_data = '0;
		pal_we = 1'b0;
		pal_addr = 8'd0;
		pal_data = 7'd0;
		max_wait = 3;
		line_no = 0;
		test_cnt = 0;
		checks = 0;
		errors = 0;
		test_name = "warm_up";
		repeat (4) @(posedge clk);
		#1;
		line_start = 1'b0;
		for (int a = 0; a < 256; a++)	// about a quarter transparent
			set_pal(8'(a), {($urandom_range(3) == 0), 6'($urandom)});
		clear_table();
		run_line();	// flush both banks
		run_line();

		begin_test("single_4c");
		max_wait = 0;
		write_desc(3, make_desc(MODE_4C, 6'($urandom), line_no, 4, 20, 3, 21'($urandom)));
		repeat (3) run_line();
		end_test();

		begin_test("modes_16c_tc");
		max_wait = 3;
		clear_table();
		p16 = 6'($urandom);
		for (int i = 0; i < 8; i++)	// even indices of the 16c bank see through
			set_pal({p16[5:2], 4'(2 * i)}, 7'h40 | 7'(i));
		write_desc(1, make_desc(MODE_4C, 6'($urandom), line_no, 3, 40, 8, 21'($urandom)));
		write_desc(5, make_desc(MODE_16C, p16, line_no, 3, 48, 6, 21'($urandom)));
		write_desc(7, make_desc(MODE_TC, 6'd0, line_no, 3, 60, 10, 21'($urandom)));
		repeat (3) run_line();
		end_test();

		begin_test("overlap_clip");
		clear_table();
		write_desc(2, make_desc(MODE_4C, 6'($urandom), line_no, 3, 100, 4, 21'($urandom)));
		write_desc(9, make_desc(MODE_16C, 6'($urandom), line_no, 3, 110, 4, 21'($urandom)));
		write_desc(10, make_desc(MODE_4C, 6'($urandom), line_no, 3, 340, 4, 21'($urandom)));
		write_desc(12, make_desc(MODE_TC, 6'd0, line_no, 3, 506, 5, 21'($urandom)));
		write_desc(14, make_desc(MODE_16C, 6'($urandom), line_no, 3, 356, 3, 21'h1F_FFFE));
		repeat (3) run_line();
		end_test();

		begin_test("vertical_range");
		clear_table();
		write_desc(0, make_desc(MODE_4C, 6'($urandom), line_no, 0, 10, 2, 21'($urandom)));
		write_desc(4, make_desc(MODE_16C, 6'($urandom), line_no + 2, 3, 200, 5, 21'($urandom)));
		repeat (7) run_line();
		end_test();

		begin_test("clear_after_read");
		for (int s = 0; s < NUM_SPRITES; s++)
			write_desc(s, make_desc(color_mode_e'(2'(1 + $urandom_range(2))), 6'($urandom),
				line_no, 1, int'($urandom_range(359)), 1 + int'($urandom_range(5)),
				21'($urandom)));
		run_line();
		clear_table();
		repeat (2) run_line();
		for (int s = 0; s < NUM_SPRITES; s++)	// present but far below
			write_desc(s, make_desc(MODE_TC, 6'd0, line_no + 100, 4, 0, 4, 21'($urandom)));
		repeat (2) run_line();
		end_test();

		begin_test("random_tables");
		for (int n = 0; n < 40; n++)
		begin
			if (n % 5 == 0)
			begin
				for (int s = 0; s < NUM_SPRITES; s++)
					write_desc(s, rand_desc(line_no));
				repeat (16)
					set_pal(8'($urandom), {($urandom_range(3) == 0), 6'($urandom)});
			end
			run_line();
		end
		run_line();	// scans the last random line
		end_test();

		$display("tests=%0d checks=%0d errors=%0d", test_cnt, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: sprite_engine.f
rtl/sprite_pkg.sv
rtl/sprite_attr_ram.sv
rtl/sprite_seq.sv
rtl/pixel_unpack.sv
rtl/line_buffer.sv
rtl/sprite_engine.sv
testbench/sprite_engine_asserts.sv
testbench/sprite_engine_tb.sv

// File: Makefile
# Verilator build and run of the sprite engine testbench

VERILATOR ?= verilator
TOP       ?= sprite_engine_tb
FILELIST  ?= sprite_engine.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
FAIL_MSG  ?= ERRORS FOUND
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, scan $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -qx "$(PASS_MSG)" $(LOG); then echo "test failed, run incomplete"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
